//--- filelist.f
+incdir+verilog
verilog/npc_pkg.sv
verilog/npc_ctrl_if.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_alu.sv
verilog/npc_regfile.sv
verilog/npc_lsu.sv
verilog/npc_top.sv
tests/npc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f filelist.f --top-module npc_tb -o npc_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/npc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- tests/npc_tb.sv
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_tb;
  import npc_pkg::*;

  localparam int DATA_WORDS        = 256;
  localparam int HALT_QUIET_CYCLES = 20;

  logic       clk;
  logic       rst;
  logic       imem_wen;
  logic [7:0] imem_addr;
  word_t      imem_wdata;
  logic       halt;
  logic       commit_valid;
  word_t      commit_pc;
  word_t      commit_inst;
  logic [4:0] commit_rd;
  word_t      commit_wdata;

  word_t tdata [DATA_WORDS];
  int    prog_len;
  int    n_commits;
  int    rec_base;
  int    commit_idx;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  npc_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .imem_wen    (imem_wen),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .halt        (halt),
    .commit_valid(commit_valid),
    .commit_pc   (commit_pc),
    .commit_inst (commit_inst),
    .commit_rd   (commit_rd),
    .commit_wdata(commit_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic expect_word(input string field, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t ns: commit %0d %s is %h, expected %h",
                         $time, commit_idx, field, got, exp));
    end
  endtask

  task automatic check_commit(input word_t exp_pc, input word_t exp_inst,
                              input word_t exp_rd, input word_t exp_wdata);
    expect_word("pc", commit_pc, exp_pc);
    expect_word("inst", commit_inst, exp_inst);
    expect_word("rd", {27'b0, commit_rd}, exp_rd);
    expect_word("wdata", commit_wdata, exp_wdata);
  endtask

  // The core stays parked on the ebreak once halted.
  task automatic check_halt(input word_t exp_pc);
    if (dut0.pc !== exp_pc) begin
      stop_run($sformatf("FAILED at %0t ns: halted at pc %h, expected %h",
                         $time, dut0.pc, exp_pc));
    end
  endtask

  // Cycle budget counts from reset release.
  always @(posedge clk) begin
    if (!rst) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        stop_run($sformatf("Timeout after %0d cycles, the core never halted", cycle_count));
      end
    end
  end

  initial begin
    int gap;
    rst        = 1'b1;
    imem_wen   = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    commit_idx = 0;
    void'($urandom(32'ha0355b3a));

    $readmemh("tests/npc_testdata.txt", tdata);
    prog_len = int'(tdata[0]);
    if ($isunknown(tdata[0]) || prog_len == 0 || prog_len > `NPC_IMEM_WORDS) begin
      stop_run("Test data file is missing or holds no valid program");
    end
    n_commits   = int'(tdata[1 + prog_len]);
    rec_base    = 2 + prog_len;
    cycle_limit = 4 * n_commits + 50;

    // Program load while reset is held, with random idle gaps.
    @(negedge clk);
    for (int i = 0; i < prog_len; i++) begin
      gap = int'($urandom_range(0, 2));
      repeat (gap) @(negedge clk);
      imem_wen   = 1'b1;
      imem_addr  = i[7:0];
      imem_wdata = tdata[1 + i];
      @(negedge clk);
      imem_wen   = 1'b0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;

    while (commit_idx < n_commits) begin
      @(negedge clk);
      if (commit_valid) begin
        check_commit(tdata[rec_base + 4 * commit_idx],
                     tdata[rec_base + 4 * commit_idx + 1],
                     tdata[rec_base + 4 * commit_idx + 2],
                     tdata[rec_base + 4 * commit_idx + 3]);
        commit_idx = commit_idx + 1;
      end
      if (halt && commit_idx < n_commits) begin
        stop_run($sformatf("Halt rose after only %0d of %0d commits", commit_idx, n_commits));
      end
    end

    // Halt rises with the ebreak commit and nothing commits after it.
    if (!halt) begin
      stop_run("Halt did not rise with the last commit");
    end
    repeat (HALT_QUIET_CYCLES) begin
      @(negedge clk);
      if (commit_valid) begin
        stop_run("A commit arrived after the core halted");
      end
      if (!halt) begin
        stop_run("Halt dropped after the core halted");
      end
    end
    check_halt(tdata[rec_base + 4 * n_commits]);

    $display("sim passed");
    $finish;
  end

endmodule

//--- tests/npc_testdata.txt
// Layout: program word count, program words, commit count,
// then one commit per line (pc inst rd wdata), then the halt pc.
001d
123450B7 00001117 FFB00193 4011D213 01C1D293 00429313 0051A3B3 0051B433
403284B3 00748013 00900533 00102423 00802583 00738463 00100613 00739463
0051C463 00100613 0051D463 0051E463 0051F463 00100613 008006EF 00100613
07100713 000707E7 00100613 00100613 00100073
// Expected commits.
0017
00000000 123450B7 00000001 12345000
00000004 00001117 00000002 00001004
00000008 FFB00193 00000003 FFFFFFFB
0000000C 4011D213 00000004 FFFFFFFD
00000010 01C1D293 00000005 0000000F
00000014 00429313 00000006 000000F0
00000018 0051A3B3 00000007 00000001
0000001C 0051B433 00000008 00000000
00000020 403284B3 00000009 00000014
00000024 00748013 00000000 00000000
00000028 00900533 0000000A 00000014
0000002C 00102423 00000000 00000000
00000030 00802583 0000000B 12345000
00000034 00738463 00000000 00000000
0000003C 00739463 00000000 00000000
00000040 0051C463 00000000 00000000
00000048 0051D463 00000000 00000000
0000004C 0051E463 00000000 00000000
00000050 0051F463 00000000 00000000
00000058 008006EF 0000000D 0000005C
00000060 07100713 0000000E 00000071
00000064 000707E7 0000000F 00000068
00000070 00100073 00000000 00000000
// Halt pc.
00000070

//--- verilog/npc_alu.sv
`timescale 1ns/1ps

module npc_alu (
  npc_ctrl_if.dp         ctrl,
  input  npc_pkg::word_t a,
  input  npc_pkg::word_t b,
  output npc_pkg::word_t result,
  output logic           taken
);
  import npc_pkg::*;

  logic lt_s;
  logic lt_u;

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << b[4:0];
      ALU_SRL:    result = a >> b[4:0];
      ALU_SRA:    result = word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:    result = {31'b0, lt_s};
      ALU_SLTU:   result = {31'b0, lt_u};
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

  // Branch compare works on the raw register operands.
  always_comb begin
    case (ctrl.br_cond)
      BR_EQ:   taken = (a == b);
      BR_NE:   taken = (a != b);
      BR_LT:   taken = lt_s;
      BR_GE:   taken = !lt_s;
      BR_LTU:  taken = lt_u;
      BR_GEU:  taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- verilog/npc_config.svh
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// First fetch address out of reset.
`define NPC_RESET_PC 32'h0000_0000

// Memory depths in 32-bit words.
`define NPC_IMEM_WORDS 256
`define NPC_DMEM_WORDS 256

`endif

//--- verilog/npc_ctrl_if.sv
`timescale 1ns/1ps

interface npc_ctrl_if;
  import npc_pkg::*;

  alu_op_e  alu_op;
  logic     src_b_imm;
  logic     src_a_pc;
  br_cond_e br_cond;
  npc_sel_e npc_sel;
  wb_sel_e  wb_sel;
  logic     reg_wen;
  logic     mem_wen;
  logic     is_ebreak;

  modport dec (
    output alu_op, src_b_imm, src_a_pc, br_cond, npc_sel,
    output wb_sel, reg_wen, mem_wen, is_ebreak
  );

  modport dp (
    input alu_op, src_b_imm, src_a_pc, br_cond, npc_sel,
    input wb_sel, reg_wen, mem_wen, is_ebreak
  );

endinterface

//--- verilog/npc_idu.sv
`timescale 1ns/1ps

module npc_idu (
  input  npc_pkg::inst_u inst,
  npc_ctrl_if.dec        ctrl,
  output logic [4:0]     rs1,
  output logic [4:0]     rs2,
  output logic [4:0]     rd,
  output npc_pkg::word_t imm
);
  import npc_pkg::*;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam word_t      EBREAK    = 32'h0010_0073;

  logic rd_write;

  // Bit 30 selects sub only for register operands; on op-imm it is an immediate bit.
  function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt,
                                       input logic is_reg);
    case (funct3)
      3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;
  assign rd  = inst.r_fmt.rd;

  // No write reaches x0.
  assign ctrl.reg_wen = rd_write && (rd != 5'd0);

  always_comb begin
    ctrl.alu_op    = ALU_ADD;
    ctrl.src_b_imm = 1'b0;
    ctrl.src_a_pc  = 1'b0;
    ctrl.br_cond   = BR_EQ;
    ctrl.npc_sel   = NPC_SEQ;
    ctrl.wb_sel    = WB_NONE;
    ctrl.mem_wen   = 1'b0;
    ctrl.is_ebreak = 1'b0;
    rd_write       = 1'b0;
    imm            = '0;

    case (inst.r_fmt.opcode)
      OP_LUI: begin
        imm            = {inst.u_fmt.imm31_12, 12'b0};
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = WB_ALU;
        rd_write       = 1'b1;
      end
      OP_AUIPC: begin
        imm            = {inst.u_fmt.imm31_12, 12'b0};
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = WB_ALU;
        rd_write       = 1'b1;
      end
      OP_JAL: begin
        imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
               inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
        ctrl.npc_sel = NPC_JAL;
        ctrl.wb_sel  = WB_PC4;
        rd_write     = 1'b1;
      end
      OP_JALR: begin
        imm            = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0};
        ctrl.src_b_imm = 1'b1;
        ctrl.npc_sel   = NPC_JALR;
        ctrl.wb_sel    = WB_PC4;
        rd_write       = 1'b1;
      end
      OP_BRANCH: begin
        imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
               inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
        ctrl.br_cond = br_cond_e'(inst.b_fmt.funct3);
        ctrl.npc_sel = NPC_BR;
      end
      OP_LOAD: begin
        imm            = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0};
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = WB_MEM;
        rd_write       = 1'b1;
      end
      OP_STORE: begin
        imm            = {{20{inst.s_fmt.imm11_5[6]}}, inst.s_fmt.imm11_5, inst.s_fmt.imm4_0};
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_wen   = 1'b1;
      end
      OP_IMM: begin
        imm            = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0};
        ctrl.alu_op    = arith_op(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b0);
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = WB_ALU;
        rd_write       = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_op = arith_op(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b1);
        ctrl.wb_sel = WB_ALU;
        rd_write    = 1'b1;
      end
      OP_SYSTEM: begin
        ctrl.is_ebreak = (inst == EBREAK);
      end
      default: begin
        // Unknown opcodes decode as a nop.
      end
    endcase
  end

endmodule

//--- verilog/npc_ifu.sv
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_ifu (
  input  logic           clk,
  input  logic           imem_wen,
  input  logic [7:0]     imem_addr,
  input  npc_pkg::word_t imem_wdata,
  input  npc_pkg::word_t pc,
  output npc_pkg::inst_u inst
);
  import npc_pkg::*;

  word_t mem [`NPC_IMEM_WORDS];

  // Program load port.
  always_ff @(posedge clk) begin
    if (imem_wen) begin
      mem[imem_addr] <= imem_wdata;
    end
  end

  // Fetch is combinational at the current pc.
  assign inst = mem[pc[9:2]];

  // The pc is unknown only before the first reset edge.
  a_pc_aligned: assert property (
    @(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00
  ) else $error("fetch from misaligned pc %h", pc);

endmodule

//--- verilog/npc_lsu.sv
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_lsu (
  input  logic           clk,
  npc_ctrl_if.dp         ctrl,
  input  npc_pkg::word_t addr,
  input  npc_pkg::word_t wdata,
  output npc_pkg::word_t rdata
);
  import npc_pkg::*;

  word_t mem [`NPC_DMEM_WORDS];

  // Word access only, low address bits are dropped.
  always_ff @(posedge clk) begin
    if (ctrl.mem_wen) begin
      mem[addr[9:2]] <= wdata;
    end
  end

  assign rdata = mem[addr[9:2]];

  a_store_aligned: assert property (
    @(posedge clk) ctrl.mem_wen |-> addr[1:0] == 2'b00
  ) else $error("misaligned store to %h", addr);

endmodule

//--- verilog/npc_pkg.sv
package npc_pkg;

  typedef logic [31:0] word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction formats, all overlaid on one 32-bit word.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control selectors.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  // Encoded as the branch funct3.
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BR} npc_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM, WB_NONE} wb_sel_e;

endpackage

//--- verilog/npc_regfile.sv
`timescale 1ns/1ps

module npc_regfile (
  input  logic           clk,
  input  logic [4:0]     rs1,
  input  logic [4:0]     rs2,
  input  logic [4:0]     rd,
  input  logic           wen,
  input  npc_pkg::word_t wdata,
  output npc_pkg::word_t src1,
  output npc_pkg::word_t src2
);
  import npc_pkg::*;

  // x0 has no storage.
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- verilog/npc_top.sv
`timescale 1ns/1ps
`include "npc_config.svh"

module npc_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           imem_wen,
  input  logic [7:0]     imem_addr,
  input  npc_pkg::word_t imem_wdata,
  output logic           halt,
  output logic           commit_valid,
  output npc_pkg::word_t commit_pc,
  output npc_pkg::word_t commit_inst,
  output logic [4:0]     commit_rd,
  output npc_pkg::word_t commit_wdata
);
  import npc_pkg::*;

  // addi x0, x0, 0
  localparam word_t INST_NOP = 32'h0000_0013;

  npc_ctrl_if ctrl ();

  word_t      pc;
  word_t      pc_next;
  word_t      pc_plus4;
  word_t      pc_target;
  inst_u      inst;
  inst_u      dec_inst;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  word_t      imm;
  word_t      src1;
  word_t      src2;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       taken;
  word_t      mem_rdata;
  word_t      wb_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch and decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  npc_ifu ifu0 (
    .clk       (clk),
    .imem_wen  (imem_wen),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .pc        (pc),
    .inst      (inst)
  );

  // Once halted, a nop is decoded so no register or memory write occurs.
  assign dec_inst = halt ? inst_u'(INST_NOP) : inst;

  npc_idu idu0 (
    .inst(dec_inst),
    .ctrl(ctrl.dec),
    .rs1 (rs1),
    .rs2 (rs2),
    .rd  (rd),
    .imm (imm)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute and memory.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  npc_regfile rf0 (
    .clk  (clk),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd),
    .wen  (ctrl.reg_wen),
    .wdata(wb_data),
    .src1 (src1),
    .src2 (src2)
  );

  assign alu_a = ctrl.src_a_pc ? pc : src1;
  assign alu_b = ctrl.src_b_imm ? imm : src2;

  npc_alu alu0 (
    .ctrl  (ctrl.dp),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result),
    .taken (taken)
  );

  npc_lsu lsu0 (
    .clk  (clk),
    .ctrl (ctrl.dp),
    .addr (alu_result),
    .wdata(src2),
    .rdata(mem_rdata)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:  wb_data = alu_result;
      WB_PC4:  wb_data = pc_plus4;
      WB_MEM:  wb_data = mem_rdata;
      default: wb_data = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next pc, halt and commit trace.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (ctrl.npc_sel)
      NPC_SEQ:  pc_next = pc_plus4;
      NPC_JAL:  pc_next = pc_target;
      NPC_JALR: pc_next = {alu_result[31:1], 1'b0};
      default:  pc_next = taken ? pc_target : pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `NPC_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      // ebreak holds the pc on itself.
      pc   <= ctrl.is_ebreak ? pc : pc_next;
      halt <= ctrl.is_ebreak;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= !halt;
    end
  end

  always_ff @(posedge clk) begin
    commit_pc    <= pc;
    commit_inst  <= inst;
    commit_rd    <= ctrl.reg_wen ? rd : 5'd0;
    commit_wdata <= ctrl.reg_wen ? wb_data : '0;
  end

endmodule
